// File: source/cmdproc_defines.svh
//----------------------------------------------------------------------
// command processor constants
// frame length, firmware version, command codes and threshold scaling
//----------------------------------------------------------------------
`ifndef CMDPROC_DEFINES_SVH
`define CMDPROC_DEFINES_SVH

`define FRAME_BYTES    8        // bytes per command frame
`define FW_VERSION     32'd19   // returned by info selector 0

// command codes, carried in byte 0
`define CMD_INFO       8'd2
`define CMD_CLKSWITCH  8'd7
`define CMD_TRIG_CFG   8'd8
`define CMD_ACQ_CFG    8'd9
`define CMD_BOARDOUT   8'd10

// info sub-selectors, carried in byte 1
`define INFO_VERSION   8'd0
`define INFO_BOARDIN   8'd1
`define INFO_OVERRANGE 8'd2

`define THRESH_OFFSET  12'd128  // adc mid-scale
`define THRESH_SHIFT   4        // 8-bit setting up to 12-bit samples
`define THRESH_ROUND   12'd8    // half lsb of the shifted value
`define N_OVERRANGE    4        // ora0, ora1, orb0, orb1

`endif

// File: source/cmdproc_pkg.sv
//----------------------------------------------------------------------
// command processor types
// vectors, frame and configuration structs, reply fsm states
//----------------------------------------------------------------------
`include "cmdproc_defines.svh"

package cmdproc_pkg;

	typedef logic [7:0]         byte_t;      // one stream byte
	typedef logic [31:0]        word_t;      // reply word, also counter width
	typedef logic signed [11:0] thresh_t;    // matches adc sample width
	typedef logic [9:0]         preoffset_t; // ram address offset

	// b0 is the command code, sits in the msbs
	typedef struct packed {
		byte_t b0;
		byte_t b1;
		byte_t b2;
		byte_t b3;
		byte_t b4;
		byte_t b5;
		byte_t b6;
		byte_t b7;
	} cmd_frame_t;

	typedef struct packed {
		thresh_t    lower_thresh;
		thresh_t    upper_thresh;
		preoffset_t pre_offset;   // samples kept before trigger
		byte_t      tot;          // time over threshold
		logic       trig_chan;
	} trig_cfg_t;

	typedef struct packed {
		logic [4:0] downsample;   // power-of-two exponent
		logic       highres;      // sum instead of decimate
		byte_t      merging;
	} acq_cfg_t;

	typedef word_t [`N_OVERRANGE-1:0] ovr_counts_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_DATA,
		TX_CLOSE
	} tx_state_t;

endpackage

// File: source/cmd_frame_rx.sv
//----------------------------------------------------------------------
// command frame receiver
// collects eight stream bytes and holds off until re-armed
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "cmdproc_defines.svh"

module cmd_frame_rx (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   i_tvalid,
	input  cmdproc_pkg::byte_t     i_tdata,
	input  logic                   i_rearm,     // reply sent or frame dropped
	output logic                   o_tready,
	output cmdproc_pkg::cmd_frame_t o_frame,
	output logic                   o_frame_stb
);

	localparam int CNT_W = $clog2(`FRAME_BYTES);

	logic [CNT_W-1:0]               byte_cnt;   // slot of the next byte
	logic [(`FRAME_BYTES-1)*8-1:0]  shift_q;    // first bytes of the frame
	logic                           take;
	logic                           last_byte;

	assign take      = i_tvalid & o_tready;
	assign last_byte = (byte_cnt == CNT_W'(`FRAME_BYTES - 1));

	//------------------------------------------------------------------
	// control
	//------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt    <= '0;
			o_tready    <= 1'b1;              // armed out of reset
			o_frame_stb <= 1'b0;
		end else begin
			o_frame_stb <= 1'b0;
			if (take) begin
				if (last_byte) begin
					byte_cnt    <= '0;
					o_frame_stb <= 1'b1;
					o_tready    <= 1'b0;      // one frame in flight
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end else if (i_rearm) begin
				o_tready <= 1'b1;
			end
		end
	end

	// earlier bytes shift up so byte 0 lands in b0
	always_ff @(posedge clk) begin
		if (take) begin
			shift_q <= {shift_q[(`FRAME_BYTES-2)*8-1:0], i_tdata};
			if (last_byte)
				o_frame <= cmdproc_pkg::cmd_frame_t'({shift_q, i_tdata});
		end
	end

endmodule

// File: source/overrange_counter.sv
//----------------------------------------------------------------------
// adc overrange counters
// one free-running count per flag, wraps at 32 bits
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "cmdproc_defines.svh"

module overrange_counter (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic [`N_OVERRANGE-1:0]  i_overrange,  // one flag per adc half
	output cmdproc_pkg::ovr_counts_t o_counts
);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_counts <= '0;
		end else begin
			for (int k = 0; k < `N_OVERRANGE; k++) begin
				if (i_overrange[k])
					o_counts[k] <= o_counts[k] + 1'b1; // count every edge flag is high
			end
		end
	end

endmodule

// File: source/cmd_decoder.sv
//----------------------------------------------------------------------
// command decoder
// executes a frame, keeps the configuration registers, forms the reply
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "cmdproc_defines.svh"

module cmd_decoder (
	input  logic                    clk,
	input  logic                    rstn,
	input  cmdproc_pkg::cmd_frame_t i_frame,
	input  logic                    i_frame_stb,
	input  cmdproc_pkg::byte_t      i_boardin,
	input  logic [3:0]              i_lockinfo,  // locked, activeclock, clkbad0/1
	input  cmdproc_pkg::ovr_counts_t i_counts,
	output cmdproc_pkg::trig_cfg_t  o_trig_cfg,
	output cmdproc_pkg::acq_cfg_t   o_acq_cfg,
	output cmdproc_pkg::byte_t      o_boardout,
	output logic                    o_clkswitch,
	output cmdproc_pkg::word_t      o_reply_word,
	output logic                    o_reply_stb,
	output logic                    o_drop        // unknown code, no reply
);

	logic [11:0]          b1_ext;
	logic [11:0]          b2_ext;
	cmdproc_pkg::thresh_t lo_thresh;
	cmdproc_pkg::thresh_t hi_thresh;
	cmdproc_pkg::word_t   info_word;

	//------------------------------------------------------------------
	// threshold scaling, 8-bit setting to 12-bit sample range
	//------------------------------------------------------------------
	assign b1_ext    = {4'd0, i_frame.b1};
	assign b2_ext    = {4'd0, i_frame.b2};
	// centre minus/plus half width, all modulo 12 bits
	assign lo_thresh = ((b1_ext - b2_ext - `THRESH_OFFSET) << `THRESH_SHIFT) + `THRESH_ROUND;
	assign hi_thresh = ((b1_ext + b2_ext - `THRESH_OFFSET) << `THRESH_SHIFT) + `THRESH_ROUND;

	// info read mux
	always_comb begin
		case (i_frame.b1)
			`INFO_VERSION:   info_word = `FW_VERSION;
			`INFO_BOARDIN:   info_word = {4{i_boardin}};
			`INFO_OVERRANGE: info_word = i_counts[i_frame.b2[1:0]];
			default:         info_word = '0;
		endcase
	end

	//------------------------------------------------------------------
	// configuration registers and reply strobes
	//------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_trig_cfg  <= '0;
			o_acq_cfg   <= '0;
			o_boardout  <= '0;
			o_clkswitch <= 1'b0;
			o_reply_stb <= 1'b0;
			o_drop      <= 1'b0;
		end else begin
			o_reply_stb <= 1'b0;
			o_drop      <= 1'b0;
			if (i_frame_stb) begin
				o_reply_stb <= 1'b1;               // cleared below for unknown codes
				case (i_frame.b0)
					`CMD_INFO: ;                   // read only
					`CMD_CLKSWITCH: begin
						o_clkswitch <= ~o_clkswitch;
					end
					`CMD_TRIG_CFG: begin
						o_trig_cfg.lower_thresh <= lo_thresh;
						o_trig_cfg.upper_thresh <= hi_thresh;
						o_trig_cfg.pre_offset   <= {i_frame.b3[1:0], i_frame.b4};
						o_trig_cfg.tot          <= i_frame.b5;
						o_trig_cfg.trig_chan    <= i_frame.b6[0];
					end
					`CMD_ACQ_CFG: begin
						o_acq_cfg.downsample <= i_frame.b1[4:0];
						o_acq_cfg.highres    <= i_frame.b2[0];
						o_acq_cfg.merging    <= i_frame.b3;
					end
					`CMD_BOARDOUT: begin
						o_boardout[i_frame.b1[2:0]] <= i_frame.b2[0]; // one bit per command
					end
					default: begin
						o_reply_stb <= 1'b0;
						o_drop      <= 1'b1;       // re-arm the receiver silently
					end
				endcase
			end
		end
	end

	// reply word, built from register values before this update
	always_ff @(posedge clk) begin
		if (i_frame_stb) begin
			case (i_frame.b0)
				`CMD_INFO:      o_reply_word <= info_word;
				`CMD_CLKSWITCH: o_reply_word <= {20'd0, i_lockinfo, 7'd0, ~o_clkswitch};
				`CMD_TRIG_CFG:  o_reply_word <= 32'd8;    // echo of the command
				`CMD_ACQ_CFG:   o_reply_word <= 32'd9;
				`CMD_BOARDOUT:  o_reply_word <= {24'd0, o_boardout}; // previous byte
				default:        o_reply_word <= o_reply_word;
			endcase
		end
	end

endmodule

// File: source/reply_tx.sv
//----------------------------------------------------------------------
// reply transmitter
// sends one word as a full-keep data beat plus an empty closing beat
//----------------------------------------------------------------------
`timescale 1ns/1ps

module reply_tx (
	input  logic                clk,
	input  logic                rstn,
	input  cmdproc_pkg::word_t  i_reply_word,
	input  logic                i_reply_stb,
	input  logic                i_tready,
	output logic                o_tvalid,
	output cmdproc_pkg::word_t  o_tdata,
	output logic [3:0]          o_tkeep,
	output logic                o_tlast,
	output logic                o_done        // both beats accepted
);

	cmdproc_pkg::tx_state_t state;

	//------------------------------------------------------------------
	// beat sequencing
	//------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state  <= cmdproc_pkg::TX_IDLE;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				cmdproc_pkg::TX_IDLE:
					if (i_reply_stb) state <= cmdproc_pkg::TX_DATA;
				cmdproc_pkg::TX_DATA:
					if (i_tready) state <= cmdproc_pkg::TX_CLOSE; // four bytes gone
				cmdproc_pkg::TX_CLOSE:
					if (i_tready) begin
						state  <= cmdproc_pkg::TX_IDLE;
						o_done <= 1'b1;
					end
				default:
					state <= cmdproc_pkg::TX_IDLE;
			endcase
		end
	end

	// word stays put for both beats
	always_ff @(posedge clk) begin
		if (state == cmdproc_pkg::TX_IDLE && i_reply_stb)
			o_tdata <= i_reply_word;
	end

	// ft232h framing, keep follows the bytes still to send
	assign o_tvalid = (state != cmdproc_pkg::TX_IDLE);
	assign o_tkeep  = (state == cmdproc_pkg::TX_DATA) ? 4'b1111 : 4'b0000;
	assign o_tlast  = (state == cmdproc_pkg::TX_CLOSE);

endmodule

// File: source/command_processor.sv
//----------------------------------------------------------------------
// command processor top
// frame receiver, decoder, reply transmitter and overrange counters
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "cmdproc_defines.svh"

module command_processor (
	input  logic                    clk,
	input  logic                    rstn,
	// command stream in
	input  logic                    i_tvalid,
	input  cmdproc_pkg::byte_t      i_tdata,
	output logic                    o_tready,
	// reply stream out
	output logic                    o_tvalid,
	output cmdproc_pkg::word_t      o_tdata,
	output logic [3:0]              o_tkeep,
	output logic                    o_tlast,
	input  logic                    i_tready,
	// board side
	input  cmdproc_pkg::byte_t      i_boardin,
	input  logic [3:0]              i_lockinfo,
	input  logic [`N_OVERRANGE-1:0] i_overrange,
	output cmdproc_pkg::trig_cfg_t  o_trig_cfg,
	output cmdproc_pkg::acq_cfg_t   o_acq_cfg,
	output cmdproc_pkg::byte_t      o_boardout,
	output logic                    o_clkswitch
);

	cmdproc_pkg::cmd_frame_t  frame;
	logic                     frame_stb;
	cmdproc_pkg::word_t       reply_word;
	logic                     reply_stb;
	logic                     done;
	logic                     drop;
	logic                     rearm;
	cmdproc_pkg::ovr_counts_t counts;

	assign rearm = done | drop;   // frame finished either way

	cmd_frame_rx cmd_frame_rx_inst (
		.clk         (clk),
		.rstn        (rstn),
		.i_tvalid    (i_tvalid),
		.i_tdata     (i_tdata),
		.i_rearm     (rearm),
		.o_tready    (o_tready),
		.o_frame     (frame),
		.o_frame_stb (frame_stb)
	);

	overrange_counter overrange_counter_inst (
		.clk         (clk),
		.rstn        (rstn),
		.i_overrange (i_overrange),
		.o_counts    (counts)
	);

	cmd_decoder cmd_decoder_inst (
		.clk          (clk),
		.rstn         (rstn),
		.i_frame      (frame),
		.i_frame_stb  (frame_stb),
		.i_boardin    (i_boardin),
		.i_lockinfo   (i_lockinfo),
		.i_counts     (counts),
		.o_trig_cfg   (o_trig_cfg),
		.o_acq_cfg    (o_acq_cfg),
		.o_boardout   (o_boardout),
		.o_clkswitch  (o_clkswitch),
		.o_reply_word (reply_word),
		.o_reply_stb  (reply_stb),
		.o_drop       (drop)
	);

	reply_tx reply_tx_inst (
		.clk          (clk),
		.rstn         (rstn),
		.i_reply_word (reply_word),
		.i_reply_stb  (reply_stb),
		.i_tready     (i_tready),
		.o_tvalid     (o_tvalid),
		.o_tdata      (o_tdata),
		.o_tkeep      (o_tkeep),
		.o_tlast      (o_tlast),
		.o_done       (done)
	);

endmodule

// File: bench/clk_gen.sv
//----------------------------------------------------------------------
// testbench clock and reset
// 100 ns clock, reset held low for five cycles
//----------------------------------------------------------------------
`timescale 1ns/1ps

module clk_gen (
	output logic o_clk,
	output logic o_rstn
);

	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk;   // 100 ns period
	end

	initial begin
		o_rstn = 1'b0;
		repeat (5) @(posedge o_clk);  // five full cycles in reset
		@(negedge o_clk);
		o_rstn = 1'b1;                // release away from the sampling edge
	end

endmodule

// File: bench/command_processor_chk.sv
//----------------------------------------------------------------------
// stream protocol assertions
// bound into the command processor top level
//----------------------------------------------------------------------
`timescale 1ns/1ps

module command_processor_chk (
	input logic               clk,
	input logic               rstn,
	input logic               i_rx_ready,   // command stream ready
	input logic               i_tx_valid,   // reply stream handshake
	input cmdproc_pkg::word_t i_tx_data,
	input logic [3:0]         i_tx_keep,
	input logic               i_tx_last,
	input logic               i_tx_ready
);

	// one frame in flight, input closed while a reply is out
	a_one_side: assert property (@(posedge clk) disable iff (!rstn)
		!(i_rx_ready && i_tx_valid))
		else $error("command input open while a reply beat is valid");

	// data beat has full keep, closing beat has none
	a_keep_last: assert property (@(posedge clk) disable iff (!rstn)
		i_tx_valid |-> ((i_tx_keep == 4'b1111) == !i_tx_last))
		else $error("keep and last do not match the beat type");

	a_hold: assert property (@(posedge clk) disable iff (!rstn)
		(i_tx_valid && !i_tx_ready) |=>
		($stable(i_tx_data) && $stable(i_tx_keep) && $stable(i_tx_last)))
		else $error("reply beat changed under back-pressure");

endmodule

bind command_processor command_processor_chk command_processor_chk_inst (
	.clk        (clk),
	.rstn       (rstn),
	.i_rx_ready (o_tready),
	.i_tx_valid (o_tvalid),
	.i_tx_data  (o_tdata),
	.i_tx_keep  (o_tkeep),
	.i_tx_last  (o_tlast),
	.i_tx_ready (i_tready)
);

// File: bench/command_processor_tb.sv
//----------------------------------------------------------------------
// command processor testbench
// table of frames with expected replies and settings, random tready
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "cmdproc_defines.svh"

module command_processor_tb;

	typedef struct packed {
		cmdproc_pkg::cmd_frame_t frame;
		logic                    has_reply;  // low for unknown codes
		cmdproc_pkg::word_t      reply;
		logic [7:0]              ovr_edges;  // flag edges before the frame
		cmdproc_pkg::trig_cfg_t  trig;       // settings after the frame
		cmdproc_pkg::acq_cfg_t   acq;
		cmdproc_pkg::byte_t      bout;
		logic                    clksw;
	} row_t;

	localparam int REPLY_LIMIT = 100;         // cycles from last byte to re-arm

	logic                     clk;
	logic                     rstn;
	logic                     i_tvalid;
	cmdproc_pkg::byte_t       i_tdata;
	logic                     o_tready;
	logic                     o_tvalid;
	cmdproc_pkg::word_t       o_tdata;
	logic [3:0]               o_tkeep;
	logic                     o_tlast;
	logic                     i_tready;
	cmdproc_pkg::byte_t       i_boardin;
	logic [3:0]               i_lockinfo;
	logic [`N_OVERRANGE-1:0]  i_overrange;
	cmdproc_pkg::trig_cfg_t   o_trig_cfg;
	cmdproc_pkg::acq_cfg_t    o_acq_cfg;
	cmdproc_pkg::byte_t       o_boardout;
	logic                     o_clkswitch;

	row_t                     rows[$];
	cmdproc_pkg::trig_cfg_t   exp_trig;     // running expected settings
	cmdproc_pkg::acq_cfg_t    exp_acq;
	cmdproc_pkg::byte_t       exp_bout;
	logic                     exp_clksw;
	int                       seed = 9264;
	int                       checks = 0;
	int                       value_errors = 0;
	int                       other_errors = 0;

	clk_gen clk_gen_inst (
		.o_clk  (clk),
		.o_rstn (rstn)
	);

	command_processor command_processor_inst (
		.clk         (clk),
		.rstn        (rstn),
		.i_tvalid    (i_tvalid),
		.i_tdata     (i_tdata),
		.o_tready    (o_tready),
		.o_tvalid    (o_tvalid),
		.o_tdata     (o_tdata),
		.o_tkeep     (o_tkeep),
		.o_tlast     (o_tlast),
		.i_tready    (i_tready),
		.i_boardin   (i_boardin),
		.i_lockinfo  (i_lockinfo),
		.i_overrange (i_overrange),
		.o_trig_cfg  (o_trig_cfg),
		.o_acq_cfg   (o_acq_cfg),
		.o_boardout  (o_boardout),
		.o_clkswitch (o_clkswitch)
	);

	//------------------------------------------------------------------
	// reference rules and compare tasks
	//------------------------------------------------------------------
	// centre -/+ half width, minus mid-scale, scaled to 12 bits, rounded
	function automatic cmdproc_pkg::thresh_t thresh_from(input int centre, input int half,
		input logic upper);
		int v;
		v = upper ? centre + half : centre - half;
		v = ((v - `THRESH_OFFSET) << `THRESH_SHIFT) + `THRESH_ROUND;
		return v[11:0];                       // wraps like the 12-bit sample range
	endfunction

	task automatic check_word(input string what, input cmdproc_pkg::word_t got,
		input cmdproc_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_trig(input int r, input cmdproc_pkg::trig_cfg_t got,
		input cmdproc_pkg::trig_cfg_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t ns: row %0d trigger settings are %h, expected %h",
				$time, r, got, exp);
		end
	endtask

	task automatic check_acq(input int r, input cmdproc_pkg::acq_cfg_t got,
		input cmdproc_pkg::acq_cfg_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t ns: row %0d acquisition settings are %h, expected %h",
				$time, r, got, exp);
		end
	endtask

	// bytes, and single bits zero-extended to a byte
	task automatic check_bits(input string what, input cmdproc_pkg::byte_t got,
		input cmdproc_pkg::byte_t exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	//------------------------------------------------------------------
	// stimulus tasks, all driving on falling edges
	//------------------------------------------------------------------
	task automatic add_row(input cmdproc_pkg::cmd_frame_t frame, input logic has_reply,
		input cmdproc_pkg::word_t reply, input int edges);
		rows.push_back(row_t'{frame, has_reply, reply, 8'(edges),
			exp_trig, exp_acq, exp_bout, exp_clksw});
	endtask

	task automatic pulse_overrange(input int k, input int edges);
		if (edges > 0) begin
			@(negedge clk);
			i_overrange[k] = 1'b1;
			repeat (edges) @(negedge clk);    // exactly edges rising edges seen
			i_overrange = '0;
		end
	endtask

	task automatic send_frame(input cmdproc_pkg::cmd_frame_t frame);
		for (int i = 0; i < `FRAME_BYTES; i++) begin
			@(negedge clk);
			while (!o_tready)
				@(negedge clk);
			i_tvalid = 1'b1;
			i_tdata  = frame[8*(`FRAME_BYTES-i)-1 -: 8]; // b0 first
		end
		@(negedge clk);
		i_tvalid = 1'b0;
	endtask

	// random back-pressure until the receiver re-arms, beats logged on the way
	task automatic collect_reply(input int r);
		cmdproc_pkg::word_t data_q[$];
		logic [3:0]         keep_q[$];
		logic               last_q[$];
		logic               saw_valid;
		int                 cyc;
		int                 rnd;
		saw_valid = 1'b0;
		cyc       = 0;
		while (!o_tready && cyc < REPLY_LIMIT) begin
			rnd       = $random(seed);
			i_tready  = (rnd[1:0] != 2'b00);       // ready about three cycles in four
			saw_valid = saw_valid | o_tvalid;
			if (o_tvalid && i_tready) begin       // beat completes on the next edge
				data_q.push_back(o_tdata);
				keep_q.push_back(o_tkeep);
				last_q.push_back(o_tlast);
			end
			@(negedge clk);
			cyc++;
		end
		if (!o_tready) begin
			other_errors++;
			$display("row %0d: command input was not re-armed within %0d cycles",
				r, REPLY_LIMIT);
		end else if (!rows[r].has_reply) begin
			if (saw_valid) begin
				other_errors++;
				$display("row %0d: unknown command code produced a reply", r);
			end
		end else if (data_q.size() != 2) begin
			other_errors++;
			$display("row %0d: expected two reply beats but %0d arrived", r, data_q.size());
		end else begin
			check_word($sformatf("row %0d data beat", r), data_q[0], rows[r].reply);
			check_bits($sformatf("row %0d data beat keep", r), {4'd0, keep_q[0]}, 8'h0f);
			check_bits($sformatf("row %0d data beat last", r), {7'd0, last_q[0]}, 8'h00);
			check_word($sformatf("row %0d closing beat", r), data_q[1], rows[r].reply);
			check_bits($sformatf("row %0d closing keep", r), {4'd0, keep_q[1]}, 8'h00);
			check_bits($sformatf("row %0d closing last", r), {7'd0, last_q[1]}, 8'h01);
		end
	endtask

	//------------------------------------------------------------------
	// table and main sequence
	//------------------------------------------------------------------
	initial begin
		i_tvalid    = 1'b0;
		i_tdata     = '0;
		i_tready    = 1'b0;
		i_boardin   = 8'ha5;
		i_lockinfo  = 4'hb;
		i_overrange = '0;
		exp_trig    = '0;                      // everything zero out of reset
		exp_acq     = '0;
		exp_bout    = '0;
		exp_clksw   = 1'b0;

		add_row({`CMD_INFO, `INFO_VERSION, 48'd0}, 1'b1, `FW_VERSION, 0);
		add_row({`CMD_INFO, `INFO_BOARDIN, 48'd0}, 1'b1, 32'ha5a5_a5a5, 0);
		exp_trig = '{thresh_from(100, 60, 1'b0), thresh_from(100, 60, 1'b1),
			10'h234, 8'd40, 1'b1};
		add_row({`CMD_TRIG_CFG, 8'd100, 8'd60, 8'hfe, 8'h34, 8'd40, 8'h03, 8'h00},
			1'b1, 32'd8, 0);
		exp_acq = '{5'h13, 1'b1, 8'd6};
		add_row({`CMD_ACQ_CFG, 8'hf3, 8'h01, 8'd6, 32'd0}, 1'b1, 32'd9, 0);
		exp_bout = 8'h20;
		add_row({`CMD_BOARDOUT, 8'd5, 8'h01, 40'd0}, 1'b1, 32'h00, 0);   // old byte
		exp_bout = 8'h22;
		add_row({`CMD_BOARDOUT, 8'd1, 8'hff, 40'd0}, 1'b1, 32'h20, 0);
		exp_clksw = 1'b1;
		add_row({`CMD_CLKSWITCH, 56'd0}, 1'b1, 32'h0000_0b01, 0);        // lockinfo, ~old
		exp_clksw = 1'b0;
		add_row({`CMD_CLKSWITCH, 56'd0}, 1'b1, 32'h0000_0b00, 0);
		add_row({8'h55, 56'h11}, 1'b0, 32'd0, 0);                        // unknown code
		add_row({`CMD_INFO, `INFO_OVERRANGE, 8'd2, 40'd0}, 1'b1, 32'd0, 0);
		add_row({`CMD_INFO, `INFO_OVERRANGE, 8'd2, 40'd0}, 1'b1, 32'd5, 5);
		add_row({`CMD_INFO, `INFO_OVERRANGE, 8'd1, 40'd0}, 1'b1, 32'd3, 3);
		add_row({`CMD_INFO, `INFO_VERSION, 48'd0}, 1'b1, `FW_VERSION, 0);

		wait (rstn === 1'b1);
		for (int r = 0; r < rows.size(); r++) begin
			pulse_overrange(rows[r].frame.b2[1:0], rows[r].ovr_edges); // flag picked by b2
			send_frame(rows[r].frame);
			collect_reply(r);
			check_trig(r, o_trig_cfg, rows[r].trig);
			check_acq(r, o_acq_cfg, rows[r].acq);
			check_bits($sformatf("row %0d boardout", r), o_boardout, rows[r].bout);
			check_bits($sformatf("row %0d clkswitch", r), {7'd0, o_clkswitch},
				{7'd0, rows[r].clksw});
		end

		$display("summary: %0d checks, %0d value errors, %0d other errors",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// watchdog, 200 cycles per table row
	initial begin
		#1;
		repeat (rows.size() * 200) @(posedge clk);
		$display("timeout: table not finished after %0d cycles", rows.size() * 200);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+source
source/cmdproc_pkg.sv
source/cmd_frame_rx.sv
source/overrange_counter.sv
source/cmd_decoder.sv
source/reply_tx.sv
source/command_processor.sv
bench/clk_gen.sv
bench/command_processor_chk.sv
bench/command_processor_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the command processor testbench with verilator, run it, search the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module command_processor_tb -o command_processor_sim > build.log 2>&1 \
	|| { cat build.log; echo "run_sim: build failed"; exit 1; }
./obj_dir/command_processor_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "run_sim: simulation stopped with an error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run_sim: failed"; exit 1; } || echo "run_sim: passed"
